// File: rtl/rn_busy_table.sv
`timescale 1ns/100ps

module rn_busy_table
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
(
  input  logic                        i_clk,
  input  logic                        i_reset_n,

  input  rn_id_t  [DISP_SIZE*2-1:0]   i_src_rnid,
  output logic    [DISP_SIZE*2-1:0]   o_src_ready,

  // newly allocated destinations
  input  logic    [DISP_SIZE-1:0]     i_set_valid,
  input  rn_id_t  [DISP_SIZE-1:0]     i_set_rnid,

  input  rn_wb_t  [WB_PORTS-1:0]      i_phy_wr
);

  logic [PHY_REGS-1:0] r_busy;

  always_comb begin
    logic wb_hit;
    for (int s = 0; s < DISP_SIZE * 2; s++) begin
      wb_hit = 1'b0;
      for (int w = 0; w < WB_PORTS; w++) begin
        if (i_phy_wr[w].valid && (i_phy_wr[w].rnid == i_src_rnid[s])) begin
          wb_hit = 1'b1;  // same cycle writeback bypass
        end
      end
      o_src_ready[s] = (i_src_rnid[s] == '0) | ~r_busy[i_src_rnid[s]] | wb_hit;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_busy <= '0;
    end else begin
      for (int w = 0; w < WB_PORTS; w++) begin
        if (i_phy_wr[w].valid) begin
          r_busy[i_phy_wr[w].rnid] <= 1'b0;
        end
      end
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_set_valid[d]) begin
          r_busy[i_set_rnid[d]] <= 1'b1;
        end
      end
    end
  end

  // a free rnid must have been written back before it was released
  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_set_chk
      a_alloc_not_busy: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_set_valid[d] |-> !r_busy[i_set_rnid[d]]);
    end
  endgenerate

endmodule

// File: rtl/rn_cfg_pkg.sv
package rn_cfg_pkg;

  // dispatch group width
  localparam int DISP_SIZE = 2;

  // architectural register space
  localparam int ARCH_REGS = 32;
  localparam int ARCH_W    = 5;   // index width for ARCH_REGS

  // physical register space, x0 maps to rnid 0
  localparam int RNID_W    = 6;
  localparam int PHY_REGS  = 64;  // 2**RNID_W

  // writeback buses that can wake up a source
  localparam int WB_PORTS  = 2;

endpackage

// File: rtl/rn_commit_release.sv
`timescale 1ns/100ps

module rn_commit_release
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  rn_cmt_t                   i_commit,
  output logic   [DISP_SIZE-1:0]    o_push,
  output rn_id_t [DISP_SIZE-1:0]    o_push_id
);

  rn_cmt_t r_commit;

  // one cycle delay keeps the freelist push off the commit path
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_commit <= '0;
    end else begin
      r_commit <= i_commit;
    end
  end

  //   normal commit -> previous mapping is dead now, free it
  //   dead slot     -> its own allocation was never architectural
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_push[d] = r_commit.commit &
                  r_commit.slot[d].rd_valid &
                  (r_commit.slot[d].rd_arch != '0);
      if (r_commit.slot[d].dead) begin
        o_push_id[d] = r_commit.slot[d].rd_rnid;
      end else begin
        o_push_id[d] = r_commit.slot[d].old_rnid;
      end
    end
  end

endmodule

// File: rtl/rn_freelist.sv
`timescale 1ns/100ps

module rn_freelist
  import rn_cfg_pkg::*;
#(
  parameter int SIZE = 16,
  parameter int INIT = 32
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_push,
  input  logic [RNID_W-1:0] i_push_id,
  input  logic              i_pop,
  output logic [RNID_W-1:0] o_pop_id,
  output logic              o_empty
);

  localparam int PTR_W = (SIZE > 1) ? $clog2(SIZE) : 1;
  localparam int CNT_W = $clog2(SIZE + 1);

  logic [RNID_W-1:0] r_list [SIZE];
  logic [PTR_W-1:0]  r_head;
  logic [PTR_W-1:0]  r_tail;
  logic [CNT_W-1:0]  r_count;

  // wrap at SIZE so non power of two depths work
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(SIZE - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_pop_id = r_list[r_head];  // head is visible before the pop edge
  assign o_empty  = (r_count == '0);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < SIZE; i++) begin
        r_list[i] <= RNID_W'(INIT + i);
      end
      r_head  <= '0;
      r_tail  <= '0;  // full, so tail has wrapped onto head
      r_count <= CNT_W'(SIZE);
    end else begin
      if (i_push) begin
        r_list[r_tail] <= i_push_id;
        r_tail         <= ptr_inc(r_tail);
      end
      if (i_pop) begin
        r_head <= ptr_inc(r_head);
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;  // both or none
      endcase
    end
  end

  // releases are routed by commit slot, so another slot can overfill this one
  a_no_push_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> (r_count != CNT_W'(SIZE)) || i_pop);

  a_no_pop_empty: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> !o_empty);

endmodule

// File: rtl/rn_map_table.sv
`timescale 1ns/100ps

module rn_map_table
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  // source lookup, rs1 and rs2 per slot
  input  rn_arch_t [DISP_SIZE*2-1:0]   i_src_arch,
  output rn_id_t   [DISP_SIZE*2-1:0]   o_src_rnid,

  // previous mapping of each destination
  input  rn_arch_t [DISP_SIZE-1:0]     i_rd_arch,
  output rn_id_t   [DISP_SIZE-1:0]     o_rd_old_rnid,

  // group update at fire
  input  logic     [DISP_SIZE-1:0]     i_upd_valid,
  input  rn_arch_t [DISP_SIZE-1:0]     i_upd_arch,
  input  rn_id_t   [DISP_SIZE-1:0]     i_upd_rnid
);

  rn_id_t r_map [ARCH_REGS];

  always_comb begin
    for (int s = 0; s < DISP_SIZE * 2; s++) begin
      o_src_rnid[s] = r_map[i_src_arch[s]];
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rd_old_rnid[d] = r_map[i_rd_arch[d]];
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int r = 0; r < ARCH_REGS; r++) begin
        r_map[r] <= rn_id_t'(r);  // identity map out of reset
      end
    end else begin
      // ascending slot order, so the youngest writer of an arch reg wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (i_upd_valid[d] && (i_upd_arch[d] != '0)) begin
          r_map[i_upd_arch[d]] <= i_upd_rnid[d];
        end
      end
    end
  end

  // x0 stays on rnid 0, the stage must never allocate for it
  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_upd_chk
      a_no_x0_update: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_upd_valid[d] |-> (i_upd_arch[d] != '0) && (i_upd_rnid[d] != '0));
    end
  endgenerate

endmodule

// File: rtl/rn_rename_stage.sv
`timescale 1ns/100ps

module rn_rename_stage
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,

  // incoming group
  input  logic                         i_dsp_valid,
  input  rn_in_grp_t                   i_dsp_grp,
  input  logic                         i_resource_ok,
  input  logic     [DISP_SIZE-1:0]     i_fl_empty,
  input  rn_id_t   [DISP_SIZE-1:0]     i_fl_head,

  // map lookup
  output rn_arch_t [DISP_SIZE*2-1:0]   o_src_arch,
  input  rn_id_t   [DISP_SIZE*2-1:0]   i_src_rnid,
  output rn_arch_t [DISP_SIZE-1:0]     o_rd_arch,
  input  rn_id_t   [DISP_SIZE-1:0]     i_rd_old_rnid,

  // busy lookup
  input  logic     [DISP_SIZE*2-1:0]   i_src_ready,

  // allocation
  output logic     [DISP_SIZE-1:0]     o_pop,
  output logic     [DISP_SIZE-1:0]     o_upd_valid,
  output rn_id_t   [DISP_SIZE-1:0]     o_upd_rnid,

  output logic                         o_ready,
  output logic                         o_sc_valid,
  output rn_out_grp_t                  o_sc_grp
);

  logic                    w_fire;
  logic [DISP_SIZE-1:0]    w_wr_rd;     // slot really writes a non-x0 dest
  rn_id_t [DISP_SIZE-1:0]  w_new_rnid;
  rn_out_grp_t             w_grp;
  logic                    r_sc_valid;
  rn_out_grp_t             r_sc_grp;

  // every slot needs a free entry, even if it does not allocate
  assign o_ready = i_resource_ok & ~(|i_fl_empty);
  assign w_fire  = i_dsp_valid & o_ready;

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr_rd[d]        = i_dsp_grp[d].valid & i_dsp_grp[d].rd_valid &
                          (i_dsp_grp[d].rd_arch != '0);
      w_new_rnid[d]     = w_wr_rd[d] ? i_fl_head[d] : '0;
      o_src_arch[d*2]   = i_dsp_grp[d].rs1_arch;
      o_src_arch[d*2+1] = i_dsp_grp[d].rs2_arch;
      o_rd_arch[d]      = i_dsp_grp[d].rd_arch;
    end
  end

  assign o_pop       = {DISP_SIZE{w_fire}} & w_wr_rd;
  assign o_upd_valid = {DISP_SIZE{w_fire}} & w_wr_rd;
  assign o_upd_rnid  = w_new_rnid;

  // map values first, then override from older slots in the group;
  // the last match in the loop is the nearest producer
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_grp[d].valid       = i_dsp_grp[d].valid;
      w_grp[d].rd_valid    = i_dsp_grp[d].rd_valid;
      w_grp[d].rd_arch     = i_dsp_grp[d].rd_arch;
      w_grp[d].rd_rnid     = w_new_rnid[d];
      w_grp[d].rd_old_rnid = i_rd_old_rnid[d];
      w_grp[d].rs1 = '{valid: i_dsp_grp[d].rs1_valid, arch: i_dsp_grp[d].rs1_arch,
                       rnid: i_src_rnid[d*2], ready: i_src_ready[d*2]};
      w_grp[d].rs2 = '{valid: i_dsp_grp[d].rs2_valid, arch: i_dsp_grp[d].rs2_arch,
                       rnid: i_src_rnid[d*2+1], ready: i_src_ready[d*2+1]};
      for (int p = 0; p < d; p++) begin
        if (w_wr_rd[p] && i_dsp_grp[d].rs1_valid &&
            (i_dsp_grp[p].rd_arch == i_dsp_grp[d].rs1_arch)) begin
          w_grp[d].rs1.rnid  = w_new_rnid[p];
          w_grp[d].rs1.ready = 1'b0;  // producer is still in this group
        end
        if (w_wr_rd[p] && i_dsp_grp[d].rs2_valid &&
            (i_dsp_grp[p].rd_arch == i_dsp_grp[d].rs2_arch)) begin
          w_grp[d].rs2.rnid  = w_new_rnid[p];
          w_grp[d].rs2.ready = 1'b0;
        end
        if (w_wr_rd[p] && (i_dsp_grp[p].rd_arch == i_dsp_grp[d].rd_arch)) begin
          w_grp[d].rd_old_rnid = w_new_rnid[p];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_sc_valid <= 1'b0;
    end else begin
      r_sc_valid <= w_fire;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_fire) begin
      r_sc_grp <= w_grp;  // hold payload on stall
    end
  end

  assign o_sc_valid = r_sc_valid;
  assign o_sc_grp   = r_sc_grp;

endmodule

// File: rtl/rn_rename_top.sv
`timescale 1ns/100ps

module rn_rename_top
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
#(
  parameter int FLIST_SIZE = 16  // entries per slot free list
) (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_dsp_valid,
  input  rn_in_grp_t               i_dsp_grp,
  input  logic                     i_resource_ok,
  output logic                     o_ready,

  input  rn_wb_t [WB_PORTS-1:0]    i_phy_wr,
  input  rn_cmt_t                  i_commit,

  output logic                     o_sc_valid,
  output rn_out_grp_t              o_sc_grp
);

  logic     [DISP_SIZE-1:0]     w_fl_push;
  rn_id_t   [DISP_SIZE-1:0]     w_fl_push_id;
  logic     [DISP_SIZE-1:0]     w_fl_pop;
  rn_id_t   [DISP_SIZE-1:0]     w_fl_head;
  logic     [DISP_SIZE-1:0]     w_fl_empty;

  rn_arch_t [DISP_SIZE*2-1:0]   w_src_arch;
  rn_id_t   [DISP_SIZE*2-1:0]   w_src_rnid;
  logic     [DISP_SIZE*2-1:0]   w_src_ready;
  rn_arch_t [DISP_SIZE-1:0]     w_rd_arch;
  rn_id_t   [DISP_SIZE-1:0]     w_rd_old_rnid;
  logic     [DISP_SIZE-1:0]     w_upd_valid;
  rn_id_t   [DISP_SIZE-1:0]     w_upd_rnid;

  // slot d starts with the block right above the arch regs
  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_flist
      rn_freelist #(
        .SIZE (FLIST_SIZE),
        .INIT (ARCH_REGS + d * FLIST_SIZE)
      ) u_freelist (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_fl_push[d]),
        .i_push_id (w_fl_push_id[d]),
        .i_pop     (w_fl_pop[d]),
        .o_pop_id  (w_fl_head[d]),
        .o_empty   (w_fl_empty[d])
      );
    end
  endgenerate

  rn_map_table u_map (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_src_arch    (w_src_arch),
    .o_src_rnid    (w_src_rnid),
    .i_rd_arch     (w_rd_arch),
    .o_rd_old_rnid (w_rd_old_rnid),
    .i_upd_valid   (w_upd_valid),
    .i_upd_arch    (w_rd_arch),   // dest arch doubles as update index
    .i_upd_rnid    (w_upd_rnid)
  );

  // looks up the map rnid, the stage masks forwarded sources itself
  rn_busy_table u_busy (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_src_rnid  (w_src_rnid),
    .o_src_ready (w_src_ready),
    .i_set_valid (w_upd_valid),
    .i_set_rnid  (w_upd_rnid),
    .i_phy_wr    (i_phy_wr)
  );

  rn_commit_release u_release (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_commit  (i_commit),
    .o_push    (w_fl_push),
    .o_push_id (w_fl_push_id)
  );

  rn_rename_stage u_stage (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_dsp_valid   (i_dsp_valid),
    .i_dsp_grp     (i_dsp_grp),
    .i_resource_ok (i_resource_ok),
    .i_fl_empty    (w_fl_empty),
    .i_fl_head     (w_fl_head),
    .o_src_arch    (w_src_arch),
    .i_src_rnid    (w_src_rnid),
    .o_rd_arch     (w_rd_arch),
    .i_rd_old_rnid (w_rd_old_rnid),
    .i_src_ready   (w_src_ready),
    .o_pop         (w_fl_pop),
    .o_upd_valid   (w_upd_valid),
    .o_upd_rnid    (w_upd_rnid),
    .o_ready       (o_ready),
    .o_sc_valid    (o_sc_valid),
    .o_sc_grp      (o_sc_grp)
  );

endmodule

// File: rtl/rn_types_pkg.sv
package rn_types_pkg;

  import rn_cfg_pkg::*;

  typedef logic [ARCH_W-1:0] rn_arch_t;
  typedef logic [RNID_W-1:0] rn_id_t;

  // renamed source operand
  typedef struct packed {
    logic     valid;
    rn_arch_t arch;
    rn_id_t   rnid;
    logic     ready;  // no pending writeback
  } rn_src_t;

  // instruction as it arrives from decode
  typedef struct packed {
    logic     valid;
    logic     rd_valid;
    rn_arch_t rd_arch;
    logic     rs1_valid;
    rn_arch_t rs1_arch;
    logic     rs2_valid;
    rn_arch_t rs2_arch;
  } rn_in_inst_t;

  typedef rn_in_inst_t [DISP_SIZE-1:0] rn_in_grp_t;

  // instruction as handed to the scheduler
  typedef struct packed {
    logic     valid;
    logic     rd_valid;
    rn_arch_t rd_arch;
    rn_id_t   rd_rnid;
    rn_id_t   rd_old_rnid;  // freed when this instruction commits
    rn_src_t  rs1;
    rn_src_t  rs2;
  } rn_out_inst_t;

  typedef rn_out_inst_t [DISP_SIZE-1:0] rn_out_grp_t;

  typedef struct packed {
    logic   valid;
    rn_id_t rnid;
  } rn_wb_t;

  // per slot commit info
  typedef struct packed {
    logic     rd_valid;
    rn_arch_t rd_arch;
    rn_id_t   rd_rnid;
    rn_id_t   old_rnid;
    logic     dead;  // squashed, give back its own rnid
  } rn_cmt_slot_t;

  typedef struct packed {
    logic                            commit;
    rn_cmt_slot_t [DISP_SIZE-1:0]    slot;
  } rn_cmt_t;

endpackage

// File: sim.f
rtl/rn_cfg_pkg.sv
rtl/rn_types_pkg.sv
rtl/rn_freelist.sv
rtl/rn_map_table.sv
rtl/rn_busy_table.sv
rtl/rn_commit_release.sv
rtl/rn_rename_stage.sv
rtl/rn_rename_top.sv
sim/tb_rename.sv

// File: sim/tb_rename.sv
`timescale 1ns/100ps

module tb_rename
  import rn_cfg_pkg::*;
  import rn_types_pkg::*;
();

  localparam int FL_SIZE      = 16;
  localparam int RESET_CYCLES = 8;
  localparam int N_DIRECTED   = 9;
  localparam int N_FILLER     = 18;
  localparam int N_ROWS       = N_DIRECTED + N_FILLER + 2;  // two idle rows drain the pipe
  localparam int MAX_CYCLES   = N_ROWS * 4 + RESET_CYCLES;

  typedef enum logic {K_IDLE, K_DISP} kind_t;

  // one table row, applied for one cycle
  typedef struct packed {
    kind_t                 kind;
    rn_in_grp_t            grp;
    logic                  res_ok;
    rn_wb_t [WB_PORTS-1:0] wb;
    rn_cmt_t               cmt;
  } stim_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_dsp_valid;
  rn_in_grp_t            i_dsp_grp;
  logic                  i_resource_ok;
  rn_wb_t [WB_PORTS-1:0] i_phy_wr;
  rn_cmt_t               i_commit;
  logic                  o_ready;
  logic                  o_sc_valid;
  rn_out_grp_t           o_sc_grp;

  stim_t               tbl [N_ROWS];
  logic [31:0]         lcg_state = 32'h1bd9;
  int                  cycle_cnt = 0;

  // reference model state
  rn_id_t              m_map [ARCH_REGS];
  logic [PHY_REGS-1:0] m_busy;
  rn_id_t              m_fl [DISP_SIZE][$];
  rn_cmt_t             m_pend_cmt;  // commit waiting in the release register
  logic                exp_valid;
  rn_out_grp_t         exp_grp;

  rn_rename_top #(
    .FLIST_SIZE (FL_SIZE)
  ) dut_i (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_dsp_valid   (i_dsp_valid),
    .i_dsp_grp     (i_dsp_grp),
    .i_resource_ok (i_resource_ok),
    .o_ready       (o_ready),
    .i_phy_wr      (i_phy_wr),
    .i_commit      (i_commit),
    .o_sc_valid    (o_sc_valid),
    .o_sc_grp      (o_sc_grp)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      abort_run($sformatf("timeout: the run was still going after %0d cycles", MAX_CYCLES));
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s expected %0b got %0b", $time, what, exp, got));
    end
  endtask

  task automatic check_grp(input rn_out_grp_t got, input rn_out_grp_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR @%0t: %s expected %h got %h", $time, what, exp, got));
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 8;  // low bits of an LCG cycle too fast
  endfunction

  function automatic rn_in_inst_t make_inst(input bit v, input bit rdv, input int rd,
                                            input bit s1v, input int s1,
                                            input bit s2v, input int s2);
    return '{valid: v, rd_valid: rdv, rd_arch: rn_arch_t'(rd), rs1_valid: s1v,
             rs1_arch: rn_arch_t'(s1), rs2_valid: s2v, rs2_arch: rn_arch_t'(s2)};
  endfunction

  function automatic rn_cmt_slot_t make_cslot(input bit rdv, input int rd, input int rnid,
                                              input int old, input bit dead);
    return '{rd_valid: rdv, rd_arch: rn_arch_t'(rd), rd_rnid: rn_id_t'(rnid),
             old_rnid: rn_id_t'(old), dead: dead};
  endfunction

  task automatic set_disp(input int r, input rn_in_inst_t a, input rn_in_inst_t b);
    tbl[r].kind   = K_DISP;
    tbl[r].res_ok = 1'b1;
    tbl[r].grp[0] = a;
    tbl[r].grp[1] = b;
  endtask

  task automatic set_commit(input int r, input rn_cmt_slot_t a, input rn_cmt_slot_t b);
    tbl[r].kind          = K_IDLE;
    tbl[r].res_ok        = 1'b1;
    tbl[r].cmt.commit    = 1'b1;
    tbl[r].cmt.slot[0]   = a;
    tbl[r].cmt.slot[1]   = b;
  endtask

  task automatic build_table();
    logic [31:0] r;
    int          rd;
    int          a1;
    int          a2;
    int          b0;
    int          b1;
    int          b2;
    for (int i = 0; i < N_ROWS; i++) begin
      tbl[i]        = '0;
      tbl[i].res_ok = 1'b1;
    end
    set_disp(0, make_inst(1, 1, 5, 1, 1, 1, 2), make_inst(1, 1, 6, 1, 5, 1, 3));
    set_disp(1, make_inst(1, 1, 7, 1, 7, 0, 0), make_inst(1, 1, 7, 1, 7, 1, 4));
    set_disp(2, make_inst(1, 1, 0, 1, 5, 1, 6), make_inst(1, 1, 8, 1, 7, 1, 0));
    set_disp(3, make_inst(1, 0, 0, 1, 5, 0, 0), make_inst(1, 0, 0, 1, 6, 0, 0));
    tbl[3].wb[0] = '{valid: 1'b1, rnid: rn_id_t'(32)};  // same cycle wakeup
    set_disp(4, make_inst(1, 1, 9, 1, 1, 0, 0), make_inst(0, 0, 0, 0, 0, 0, 0));
    tbl[4].res_ok = 1'b0;
    set_disp(5, make_inst(1, 1, 10, 1, 5, 1, 9), make_inst(1, 0, 0, 1, 10, 0, 0));
    // dead slot 0 hands its own rnid back to the list that filler drains
    set_commit(6, make_cslot(1, 5, 32, 5, 1), make_cslot(1, 6, 48, 6, 0));
    tbl[6].wb[1] = '{valid: 1'b1, rnid: rn_id_t'(48)};
    set_commit(7, make_cslot(1, 7, 33, 7, 0), make_cslot(1, 7, 49, 33, 0));
    tbl[7].wb[0] = '{valid: 1'b1, rnid: rn_id_t'(33)};
    set_commit(8, make_cslot(1, 10, 34, 10, 0), make_cslot(1, 0, 0, 0, 0));
    // filler drains slot 0 past its reset contents, slot 1 only reads
    for (int i = N_DIRECTED; i < N_DIRECTED + N_FILLER; i++) begin
      r  = lcg_next();
      rd = 1 + lcg_next() % 31;
      a1 = lcg_next() % 32;
      a2 = lcg_next() % 32;
      b0 = lcg_next() % 32;
      b1 = lcg_next() % 32;
      b2 = lcg_next() % 32;
      set_disp(i, make_inst(1, 1, rd, 1, a1, 1, a2), make_inst(1, 0, b0, 1, b1, 1, b2));
      if (r[3:0] == 4'd0) begin
        tbl[i].kind = K_IDLE;  // occasional bubble
      end
      tbl[i].wb[0] = '{valid: r[8], rnid: rn_id_t'(32 + r[20:16])};
    end
  endtask

  task automatic model_reset();
    for (int a = 0; a < ARCH_REGS; a++) begin
      m_map[a] = rn_id_t'(a);
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      m_fl[d].delete();
      for (int k = 0; k < FL_SIZE; k++) begin
        m_fl[d].push_back(rn_id_t'(ARCH_REGS + d * FL_SIZE + k));
      end
    end
    m_busy     = '0;
    m_pend_cmt = '0;
    exp_valid  = 1'b0;
    exp_grp    = '0;
  endtask

  function automatic rn_src_t src_lookup(input logic v, input rn_arch_t a,
                                         input rn_wb_t [WB_PORTS-1:0] wb);
    rn_src_t src;
    src.valid = v;
    src.arch  = a;
    src.rnid  = m_map[a];
    src.ready = (src.rnid == '0) || !m_busy[src.rnid];
    for (int w = 0; w < WB_PORTS; w++) begin
      if (wb[w].valid && (wb[w].rnid == src.rnid)) begin
        src.ready = 1'b1;
      end
    end
    return src;
  endfunction

  // predicts o_ready now and the group that shows up one cycle later
  task automatic model_step(input stim_t s);
    logic                 ok;
    logic                 fire;
    logic [DISP_SIZE-1:0] wr;
    rn_id_t               new_id [DISP_SIZE];
    rn_out_grp_t          g;
    rn_cmt_slot_t         cs;
    ok = s.res_ok;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (m_fl[d].size() == 0) begin
        ok = 1'b0;
      end
    end
    check_bit(o_ready, ok, "o_ready");
    fire = (s.kind == K_DISP) && ok;
    for (int d = 0; d < DISP_SIZE; d++) begin
      wr[d]            = s.grp[d].valid && s.grp[d].rd_valid && (s.grp[d].rd_arch != '0);
      new_id[d]        = (wr[d] && m_fl[d].size() > 0) ? m_fl[d][0] : '0;
      g[d].valid       = s.grp[d].valid;
      g[d].rd_valid    = s.grp[d].rd_valid;
      g[d].rd_arch     = s.grp[d].rd_arch;
      g[d].rd_rnid     = new_id[d];
      g[d].rd_old_rnid = m_map[s.grp[d].rd_arch];
      g[d].rs1         = src_lookup(s.grp[d].rs1_valid, s.grp[d].rs1_arch, s.wb);
      g[d].rs2         = src_lookup(s.grp[d].rs2_valid, s.grp[d].rs2_arch, s.wb);
      for (int p = 0; p < d; p++) begin  // later p is nearer, so it overrides
        if (wr[p] && s.grp[d].rs1_valid && (s.grp[p].rd_arch == s.grp[d].rs1_arch)) begin
          g[d].rs1.rnid  = new_id[p];
          g[d].rs1.ready = 1'b0;
        end
        if (wr[p] && s.grp[d].rs2_valid && (s.grp[p].rd_arch == s.grp[d].rs2_arch)) begin
          g[d].rs2.rnid  = new_id[p];
          g[d].rs2.ready = 1'b0;
        end
        if (wr[p] && (s.grp[p].rd_arch == s.grp[d].rd_arch)) begin
          g[d].rd_old_rnid = new_id[p];
        end
      end
    end
    for (int w = 0; w < WB_PORTS; w++) begin
      if (s.wb[w].valid) begin
        m_busy[s.wb[w].rnid] = 1'b0;
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (fire && wr[d]) begin
        m_map[s.grp[d].rd_arch] = new_id[d];
        m_busy[new_id[d]]       = 1'b1;
        void'(m_fl[d].pop_front());
      end
    end
    // last cycle's commit reaches the free lists at this edge
    for (int d = 0; d < DISP_SIZE; d++) begin
      cs = m_pend_cmt.slot[d];
      if (m_pend_cmt.commit && cs.rd_valid && (cs.rd_arch != '0)) begin
        m_fl[d].push_back(cs.dead ? cs.rd_rnid : cs.old_rnid);
      end
    end
    m_pend_cmt = s.cmt;
    exp_valid  = fire;
    if (fire) begin
      exp_grp = g;
    end
  endtask

  task automatic check_output();
    check_bit(o_sc_valid, exp_valid, "o_sc_valid");
    if (exp_valid) begin
      check_grp(o_sc_grp, exp_grp, "o_sc_grp");
    end
  endtask

  task automatic apply_row(input stim_t s);
    i_dsp_valid   <= (s.kind == K_DISP);
    i_dsp_grp     <= s.grp;
    i_resource_ok <= s.res_ok;
    i_phy_wr      <= s.wb;
    i_commit      <= s.cmt;
  endtask

  initial begin
    i_reset_n     = 1'b0;
    i_dsp_valid   = 1'b0;
    i_dsp_grp     = '0;
    i_resource_ok = 1'b0;
    i_phy_wr      = '0;
    i_commit      = '0;
    build_table();
    model_reset();
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;
    for (int i = 0; i < N_ROWS; i++) begin
      @(posedge i_clk);
      apply_row(tbl[i]);
      @(negedge i_clk);  // outputs settled, away from the drive edge
      check_output();
      model_step(tbl[i]);
    end
    @(posedge i_clk);
    @(negedge i_clk);
    check_output();
    $display("*** PASSED ***");
    $finish;
  end

endmodule
